/* design/exu_pkg.sv */
package exu_pkg;

  // datapath and field widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int csr_addr_w = 12;
  localparam int hist_w     = 8;   // global history carried with a prediction

  // execute opcode from decode
  typedef enum logic [3:0] {
    exc_none,
    exc_lui,
    exc_auipc,
    exc_jal,
    exc_jalr,
    exc_load,
    exc_store,
    exc_branch,
    exc_opimm,
    exc_opreg,
    exc_csr
  } exc_op_e;

  // alu operation, the last six are branch compares
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_beq,
    alu_bne,
    alu_blt,
    alu_bge,
    alu_bltu,
    alu_bgeu
  } alu_op_e;

  // csr access kind, immediate forms share these
  typedef enum logic [1:0] {
    csr_none,
    csr_rw,
    csr_rs,
    csr_rc
  } csr_op_e;

  // jump kind reported back to the predictor
  typedef enum logic [1:0] {
    jump_none,
    jump_jal,
    jump_jalr,
    jump_branch
  } jump_type_e;

endpackage

/* design/alu.sv */
`timescale 1ns/10ps

module alu (
  input  logic [exu_pkg::xlen-1:0] alu_a_i,
  input  logic [exu_pkg::xlen-1:0] alu_b_i,
  input  exu_pkg::alu_op_e         alu_op_i,
  output logic [exu_pkg::xlen-1:0] alu_out_o,
  output logic                     compare_out_o
);

  localparam int sh_w = $clog2(exu_pkg::xlen);

  logic [sh_w-1:0] shamt;
  logic            eq;
  logic            lt_s;
  logic            lt_u;

  assign shamt = alu_b_i[sh_w-1:0];  // only the low bits count
  assign eq    = (alu_a_i == alu_b_i);
  assign lt_s  = ($signed(alu_a_i) < $signed(alu_b_i));
  assign lt_u  = (alu_a_i < alu_b_i);

  // arithmetic, logic and shifts
  always_comb begin
    case (alu_op_i)
      exu_pkg::alu_add:  alu_out_o = alu_a_i + alu_b_i;
      exu_pkg::alu_sub:  alu_out_o = alu_a_i - alu_b_i;
      exu_pkg::alu_sll:  alu_out_o = alu_a_i << shamt;
      exu_pkg::alu_slt:  alu_out_o = {{(exu_pkg::xlen-1){1'b0}}, lt_s};
      exu_pkg::alu_sltu: alu_out_o = {{(exu_pkg::xlen-1){1'b0}}, lt_u};
      exu_pkg::alu_xor:  alu_out_o = alu_a_i ^ alu_b_i;
      exu_pkg::alu_srl:  alu_out_o = alu_a_i >> shamt;
      exu_pkg::alu_sra:  alu_out_o = $signed(alu_a_i) >>> shamt;
      exu_pkg::alu_or:   alu_out_o = alu_a_i | alu_b_i;
      exu_pkg::alu_and:  alu_out_o = alu_a_i & alu_b_i;
      default:           alu_out_o = '0;  // compares give no data
    endcase
  end

  // branch conditions
  always_comb begin
    case (alu_op_i)
      exu_pkg::alu_beq:  compare_out_o = eq;
      exu_pkg::alu_bne:  compare_out_o = ~eq;
      exu_pkg::alu_blt:  compare_out_o = lt_s;
      exu_pkg::alu_bge:  compare_out_o = ~lt_s;
      exu_pkg::alu_bltu: compare_out_o = lt_u;
      exu_pkg::alu_bgeu: compare_out_o = ~lt_u;
      default:           compare_out_o = 1'b0;
    endcase
  end

endmodule

/* design/execute_csr.sv */
`timescale 1ns/10ps

module execute_csr (
  input  logic [exu_pkg::xlen-1:0] csr_data_i,      // old csr value
  input  logic [exu_pkg::xlen-1:0] rs1_data_i,
  input  logic [4:0]               csr_imm_i,       // zimm field
  input  logic                     csr_imm_valid_i,
  input  exu_pkg::csr_op_e         csr_op_i,
  output logic [exu_pkg::xlen-1:0] csr_exe_data_o,
  output logic                     csr_exe_data_valid_o
);

  logic [exu_pkg::xlen-1:0] src;
  logic                     src_zero;

  assign src = csr_imm_valid_i ? {{(exu_pkg::xlen-5){1'b0}}, csr_imm_i} : rs1_data_i;
  assign src_zero = (src == '0);

  always_comb begin
    case (csr_op_i)
      exu_pkg::csr_rw: csr_exe_data_o = src;
      exu_pkg::csr_rs: csr_exe_data_o = csr_data_i | src;   // set bits
      exu_pkg::csr_rc: csr_exe_data_o = csr_data_i & ~src;  // clear bits
      default:         csr_exe_data_o = csr_data_i;
    endcase
  end

  // set/clear with a zero source leaves the csr alone
  always_comb begin
    case (csr_op_i)
      exu_pkg::csr_rw: csr_exe_data_valid_o = 1'b1;
      exu_pkg::csr_rs,
      exu_pkg::csr_rc: csr_exe_data_valid_o = ~src_zero;
      default:         csr_exe_data_valid_o = 1'b0;
    endcase
  end

endmodule

/* design/exu.sv */
`timescale 1ns/10ps

module exu (
  input  logic                           issue_valid_i,
  input  logic                           mem_stall_i,
  input  logic [exu_pkg::xlen-1:0]       inst_addr_i,
  input  logic [exu_pkg::reg_addr_w-1:0] rd_idx_i,
  input  logic [exu_pkg::xlen-1:0]       rs1_data_i,
  input  logic [exu_pkg::xlen-1:0]       rs2_data_i,
  input  logic [exu_pkg::xlen-1:0]       imm_data_i,
  input  exu_pkg::exc_op_e               exc_op_i,
  input  exu_pkg::alu_op_e               alu_op_i,
  input  logic [exu_pkg::csr_addr_w-1:0] csr_addr_i,
  input  logic [exu_pkg::xlen-1:0]       csr_data_i,
  input  logic [4:0]                     csr_imm_i,
  input  logic                           csr_imm_valid_i,
  input  exu_pkg::csr_op_e               csr_op_i,
  input  logic                           pdt_res_i,     // predicted direction
  input  logic [exu_pkg::xlen-1:0]       pdt_tag_i,
  input  logic                           which_pdt_i,
  input  logic [exu_pkg::hist_w-1:0]     history_i,
  output logic [exu_pkg::xlen-1:0]       alu_data_o,
  output logic [exu_pkg::reg_addr_w-1:0] rd_idx_o,
  output exu_pkg::exc_op_e               exc_op_o,
  output logic [exu_pkg::xlen-1:0]       rs2_data_o,
  output logic                           csr_valid_o,
  output logic [exu_pkg::csr_addr_w-1:0] csr_addr_o,
  output logic [exu_pkg::xlen-1:0]       csr_data_o,
  output logic [exu_pkg::xlen-1:0]       redirect_pc_o,
  output logic                           redirect_pc_valid_o,
  output logic                           bpu_valid_o,
  output logic                           branch_taken_o,
  output logic                           pdt_correct_o,
  output logic                           which_pdt_o,
  output logic [exu_pkg::hist_w-1:0]     history_o,
  output exu_pkg::jump_type_e            jump_type_o,
  output logic                           fire_o
);

  logic                     is_jal;
  logic                     is_jalr;
  logic                     is_branch;
  logic                     is_jump;
  logic [exu_pkg::xlen-1:0] upper_imm;
  logic [exu_pkg::xlen-1:0] alu_a;
  logic [exu_pkg::xlen-1:0] alu_b;
  logic                     compare_out;
  logic                     taken;
  logic                     correct;
  logic                     fall_through;
  logic [exu_pkg::xlen-1:0] target_base;
  logic [exu_pkg::xlen-1:0] target_off;
  logic [exu_pkg::xlen-1:0] target_sum;
  logic                     csr_new_valid;

  assign is_jal    = (exc_op_i == exu_pkg::exc_jal);
  assign is_jalr   = (exc_op_i == exu_pkg::exc_jalr);
  assign is_branch = (exc_op_i == exu_pkg::exc_branch);
  assign is_jump   = is_jal | is_jalr | is_branch;

  assign upper_imm = {imm_data_i[exu_pkg::xlen-1:12], 12'b0};  // lui/auipc

  // alu operands
  always_comb begin
    alu_a = '0;
    alu_b = '0;
    case (exc_op_i)
      exu_pkg::exc_opreg, exu_pkg::exc_branch: begin
        alu_a = rs1_data_i;
        alu_b = rs2_data_i;
      end
      exu_pkg::exc_opimm, exu_pkg::exc_load, exu_pkg::exc_store: begin
        alu_a = rs1_data_i;
        alu_b = imm_data_i;
      end
      exu_pkg::exc_jal, exu_pkg::exc_jalr: begin
        alu_a = inst_addr_i;
        alu_b = exu_pkg::xlen'(4);   // link address
      end
      exu_pkg::exc_auipc: begin
        alu_a = inst_addr_i;
        alu_b = upper_imm;
      end
      exu_pkg::exc_lui: alu_b = upper_imm;
      exu_pkg::exc_csr: alu_b = csr_data_i;  // old csr goes to rd
      default: ;
    endcase
  end

  alu u_alu (
    .alu_a_i       (alu_a),
    .alu_b_i       (alu_b),
    .alu_op_i      (alu_op_i),
    .alu_out_o     (alu_data_o),
    .compare_out_o (compare_out)
  );

  execute_csr u_execute_csr (
    .csr_data_i           (csr_data_i),
    .rs1_data_i           (rs1_data_i),
    .csr_imm_i            (csr_imm_i),
    .csr_imm_valid_i      (csr_imm_valid_i),
    .csr_op_i             (csr_op_i),
    .csr_exe_data_o       (csr_data_o),
    .csr_exe_data_valid_o (csr_new_valid)
  );

  assign csr_valid_o = csr_new_valid & (exc_op_i == exu_pkg::exc_csr);
  assign csr_addr_o  = csr_addr_i;
  assign rd_idx_o    = rd_idx_i;
  assign exc_op_o    = exc_op_i;
  assign rs2_data_o  = rs2_data_i;

  // branch resolution
  assign taken   = (is_branch & compare_out) | is_jal | is_jalr;
  assign correct = (taken == pdt_res_i) & (~pdt_res_i | (pdt_tag_i == inst_addr_i));

  // predicted taken but fell through, go back to pc+4
  assign fall_through = pdt_res_i & ~taken;
  assign target_base  = fall_through ? inst_addr_i : (is_jalr ? rs1_data_i : inst_addr_i);
  assign target_off   = fall_through ? exu_pkg::xlen'(4) : imm_data_i;
  assign target_sum   = target_base + target_off;

  assign redirect_pc_o       = {target_sum[exu_pkg::xlen-1:1], target_sum[0] & ~is_jalr};
  assign redirect_pc_valid_o = issue_valid_i & is_jump & ~correct;

  assign fire_o         = issue_valid_i & ~mem_stall_i;
  assign bpu_valid_o    = issue_valid_i & is_jump;
  assign branch_taken_o = taken;
  assign pdt_correct_o  = issue_valid_i & correct;
  assign which_pdt_o    = which_pdt_i;
  assign history_o      = history_i;

  always_comb begin
    case (exc_op_i)
      exu_pkg::exc_jal:    jump_type_o = exu_pkg::jump_jal;
      exu_pkg::exc_jalr:   jump_type_o = exu_pkg::jump_jalr;
      exu_pkg::exc_branch: jump_type_o = exu_pkg::jump_branch;
      default:             jump_type_o = exu_pkg::jump_none;
    endcase
  end

endmodule

/* design/ex_mem_reg.sv */
`timescale 1ns/10ps

module ex_mem_reg (
  input  logic                           clk,
  input  logic                           reset_i,
  input  logic                           fire_i,
  input  logic                           mem_stall_i,
  input  logic [exu_pkg::xlen-1:0]       alu_data_i,
  input  logic [exu_pkg::reg_addr_w-1:0] rd_idx_i,
  input  exu_pkg::exc_op_e               exc_op_i,
  input  logic                           csr_valid_i,
  input  logic [exu_pkg::csr_addr_w-1:0] csr_addr_i,
  input  logic [exu_pkg::xlen-1:0]       csr_data_i,
  input  logic [exu_pkg::xlen-1:0]       rs2_data_i,
  output logic                           mem_valid_o,
  output logic [exu_pkg::xlen-1:0]       mem_alu_data_o,
  output logic [exu_pkg::reg_addr_w-1:0] mem_rd_idx_o,
  output exu_pkg::exc_op_e               mem_exc_op_o,
  output logic                           mem_csr_valid_o,
  output logic [exu_pkg::csr_addr_w-1:0] mem_csr_addr_o,
  output logic [exu_pkg::xlen-1:0]       mem_csr_data_o,
  output logic [exu_pkg::xlen-1:0]       mem_rs2_data_o
);

  // control, bubble when nothing fires
  always_ff @(posedge clk) begin
    if (reset_i) begin
      mem_valid_o     <= 1'b0;
      mem_csr_valid_o <= 1'b0;
      mem_exc_op_o    <= exu_pkg::exc_none;
    end else if (!mem_stall_i) begin
      mem_valid_o     <= fire_i;
      mem_csr_valid_o <= fire_i & csr_valid_i;
      mem_exc_op_o    <= fire_i ? exc_op_i : exu_pkg::exc_none;
    end
  end

  // payload only moves on a fire
  always_ff @(posedge clk) begin
    if (fire_i) begin
      mem_alu_data_o <= alu_data_i;
      mem_rd_idx_o   <= rd_idx_i;
      mem_csr_addr_o <= csr_addr_i;
      mem_csr_data_o <= csr_data_i;
      mem_rs2_data_o <= rs2_data_i;  // store data
    end
  end

endmodule

/* design/bpu_stat.sv */
`timescale 1ns/10ps

module bpu_stat #(
  parameter int cnt_w = 16
) (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             fire_i,
  input  logic             bpu_valid_i,    // branch-type instruction
  input  logic             pdt_correct_i,
  output logic [cnt_w-1:0] branch_cnt_o,
  output logic [cnt_w-1:0] correct_cnt_o
);

  logic count_en;
  logic branch_full;
  logic correct_full;

  assign count_en     = fire_i & bpu_valid_i;
  assign branch_full  = &branch_cnt_o;
  assign correct_full = &correct_cnt_o;

  // resolved branches, stops at all ones
  always_ff @(posedge clk) begin
    if (reset_i) begin
      branch_cnt_o <= '0;
    end else if (count_en && !branch_full) begin
      branch_cnt_o <= branch_cnt_o + 1'b1;
    end
  end

  // correctly predicted ones
  always_ff @(posedge clk) begin
    if (reset_i) begin
      correct_cnt_o <= '0;
    end else if (count_en && pdt_correct_i && !correct_full) begin
      correct_cnt_o <= correct_cnt_o + 1'b1;
    end
  end

endmodule

/* design/exu_top.sv */
`timescale 1ns/10ps

module exu_top #(
  parameter int cnt_w = 16
) (
  input  logic                           clk,
  input  logic                           reset_i,
  input  logic                           issue_valid_i,
  input  logic                           mem_stall_i,
  input  logic [exu_pkg::xlen-1:0]       inst_addr_i,
  input  logic [exu_pkg::reg_addr_w-1:0] rd_idx_i,
  input  logic [exu_pkg::xlen-1:0]       rs1_data_i,
  input  logic [exu_pkg::xlen-1:0]       rs2_data_i,
  input  logic [exu_pkg::xlen-1:0]       imm_data_i,
  input  exu_pkg::exc_op_e               exc_op_i,
  input  exu_pkg::alu_op_e               alu_op_i,
  input  logic [exu_pkg::csr_addr_w-1:0] csr_addr_i,
  input  logic [exu_pkg::xlen-1:0]       csr_data_i,
  input  logic [4:0]                     csr_imm_i,
  input  logic                           csr_imm_valid_i,
  input  exu_pkg::csr_op_e               csr_op_i,
  input  logic                           pdt_res_i,
  input  logic [exu_pkg::xlen-1:0]       pdt_tag_i,
  input  logic                           which_pdt_i,
  input  logic [exu_pkg::hist_w-1:0]     history_i,
  output logic                           mem_valid_o,
  output logic [exu_pkg::xlen-1:0]       mem_alu_data_o,
  output logic [exu_pkg::reg_addr_w-1:0] mem_rd_idx_o,
  output exu_pkg::exc_op_e               mem_exc_op_o,
  output logic                           mem_csr_valid_o,
  output logic [exu_pkg::csr_addr_w-1:0] mem_csr_addr_o,
  output logic [exu_pkg::xlen-1:0]       mem_csr_data_o,
  output logic [exu_pkg::xlen-1:0]       mem_rs2_data_o,
  output logic [exu_pkg::xlen-1:0]       redirect_pc_o,
  output logic                           redirect_pc_valid_o,
  output logic                           bpu_valid_o,
  output logic                           branch_taken_o,
  output logic                           pdt_correct_o,
  output logic                           which_pdt_o,
  output logic [exu_pkg::hist_w-1:0]     history_o,
  output exu_pkg::jump_type_e            jump_type_o,
  output logic [cnt_w-1:0]               branch_cnt_o,
  output logic [cnt_w-1:0]               correct_cnt_o
);

  logic [exu_pkg::xlen-1:0]       ex_alu_data;
  logic [exu_pkg::reg_addr_w-1:0] ex_rd_idx;
  exu_pkg::exc_op_e               ex_exc_op;
  logic [exu_pkg::xlen-1:0]       ex_rs2_data;
  logic                           ex_csr_valid;
  logic [exu_pkg::csr_addr_w-1:0] ex_csr_addr;
  logic [exu_pkg::xlen-1:0]       ex_csr_data;
  logic                           fire;

  exu u_exu (
    .issue_valid_i (issue_valid_i), .mem_stall_i (mem_stall_i),
    .inst_addr_i (inst_addr_i), .rd_idx_i (rd_idx_i),
    .rs1_data_i (rs1_data_i), .rs2_data_i (rs2_data_i), .imm_data_i (imm_data_i),
    .exc_op_i (exc_op_i), .alu_op_i (alu_op_i),
    .csr_addr_i (csr_addr_i), .csr_data_i (csr_data_i), .csr_imm_i (csr_imm_i),
    .csr_imm_valid_i (csr_imm_valid_i), .csr_op_i (csr_op_i),
    .pdt_res_i (pdt_res_i), .pdt_tag_i (pdt_tag_i),
    .which_pdt_i (which_pdt_i), .history_i (history_i),
    .alu_data_o (ex_alu_data), .rd_idx_o (ex_rd_idx), .exc_op_o (ex_exc_op),
    .rs2_data_o (ex_rs2_data), .csr_valid_o (ex_csr_valid),
    .csr_addr_o (ex_csr_addr), .csr_data_o (ex_csr_data),
    .redirect_pc_o (redirect_pc_o), .redirect_pc_valid_o (redirect_pc_valid_o),
    .bpu_valid_o (bpu_valid_o), .branch_taken_o (branch_taken_o),
    .pdt_correct_o (pdt_correct_o), .which_pdt_o (which_pdt_o),
    .history_o (history_o), .jump_type_o (jump_type_o), .fire_o (fire)
  );

  ex_mem_reg u_ex_mem_reg (
    .clk (clk), .reset_i (reset_i), .fire_i (fire), .mem_stall_i (mem_stall_i),
    .alu_data_i (ex_alu_data), .rd_idx_i (ex_rd_idx), .exc_op_i (ex_exc_op),
    .csr_valid_i (ex_csr_valid), .csr_addr_i (ex_csr_addr),
    .csr_data_i (ex_csr_data), .rs2_data_i (ex_rs2_data),
    .mem_valid_o (mem_valid_o), .mem_alu_data_o (mem_alu_data_o),
    .mem_rd_idx_o (mem_rd_idx_o), .mem_exc_op_o (mem_exc_op_o),
    .mem_csr_valid_o (mem_csr_valid_o), .mem_csr_addr_o (mem_csr_addr_o),
    .mem_csr_data_o (mem_csr_data_o), .mem_rs2_data_o (mem_rs2_data_o)
  );

  // prediction accuracy counters
  bpu_stat #(
    .cnt_w (cnt_w)
  ) u_bpu_stat (
    .clk (clk), .reset_i (reset_i), .fire_i (fire),
    .bpu_valid_i (bpu_valid_o), .pdt_correct_i (pdt_correct_o),
    .branch_cnt_o (branch_cnt_o), .correct_cnt_o (correct_cnt_o)
  );

endmodule

/* bench/exu_model.svh */
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

// integer alu, compares give zero
function automatic logic [31:0] alu_result(logic [31:0] a, logic [31:0] b,
                                           exu_pkg::alu_op_e op);
  case (op)
    exu_pkg::alu_add:  return a + b;
    exu_pkg::alu_sub:  return a - b;
    exu_pkg::alu_sll:  return a << b[4:0];
    exu_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    exu_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
    exu_pkg::alu_xor:  return a ^ b;
    exu_pkg::alu_srl:  return a >> b[4:0];
    exu_pkg::alu_sra:  return $signed(a) >>> b[4:0];
    exu_pkg::alu_or:   return a | b;
    exu_pkg::alu_and:  return a & b;
    default:           return 32'd0;
  endcase
endfunction

// result for rd, operands picked by execute opcode
function automatic logic [31:0] execute_result(exu_pkg::exc_op_e op, exu_pkg::alu_op_e aop,
    logic [31:0] pc, logic [31:0] rs1, logic [31:0] rs2, logic [31:0] imm, logic [31:0] csr_old);
  logic [31:0] upper;
  upper = imm & 32'hffff_f000;
  case (op)
    exu_pkg::exc_opreg, exu_pkg::exc_branch: return alu_result(rs1, rs2, aop);
    exu_pkg::exc_opimm, exu_pkg::exc_load, exu_pkg::exc_store: return alu_result(rs1, imm, aop);
    exu_pkg::exc_jal, exu_pkg::exc_jalr: return alu_result(pc, 32'd4, aop);
    exu_pkg::exc_auipc: return alu_result(pc, upper, aop);
    exu_pkg::exc_lui:   return alu_result(32'd0, upper, aop);
    exu_pkg::exc_csr:   return alu_result(32'd0, csr_old, aop);
    default:            return alu_result(32'd0, 32'd0, aop);
  endcase
endfunction

function automatic logic [31:0] csr_source(logic [31:0] rs1, logic [4:0] zimm, logic use_imm);
  return use_imm ? {27'd0, zimm} : rs1;
endfunction

function automatic logic [31:0] csr_new_value(logic [31:0] old, logic [31:0] src,
                                              exu_pkg::csr_op_e cop);
  case (cop)
    exu_pkg::csr_rw: return src;
    exu_pkg::csr_rs: return old | src;
    exu_pkg::csr_rc: return old & ~src;
    default:         return old;
  endcase
endfunction

// set and clear with a zero source write nothing
function automatic logic csr_writes(logic [31:0] src, exu_pkg::csr_op_e cop);
  if (cop == exu_pkg::csr_none) return 1'b0;
  if (cop == exu_pkg::csr_rw) return 1'b1;
  return src != 32'd0;
endfunction

function automatic logic resolve_taken(exu_pkg::exc_op_e op, exu_pkg::alu_op_e aop,
                                       logic [31:0] a, logic [31:0] b);
  if (op == exu_pkg::exc_jal || op == exu_pkg::exc_jalr) return 1'b1;
  if (op != exu_pkg::exc_branch) return 1'b0;
  case (aop)
    exu_pkg::alu_beq:  return a == b;
    exu_pkg::alu_bne:  return a != b;
    exu_pkg::alu_blt:  return $signed(a) < $signed(b);
    exu_pkg::alu_bge:  return $signed(a) >= $signed(b);
    exu_pkg::alu_bltu: return a < b;
    exu_pkg::alu_bgeu: return a >= b;
    default:           return 1'b0;
  endcase
endfunction

function automatic logic prediction_ok(logic taken, logic pdt, logic [31:0] tag, logic [31:0] pc);
  return (taken == pdt) && (!pdt || tag == pc);
endfunction

function automatic logic [31:0] redirect_target(exu_pkg::exc_op_e op, logic taken, logic pdt,
                                                logic [31:0] pc, logic [31:0] rs1,
                                                logic [31:0] imm);
  if (pdt && !taken) return pc + 32'd4;  // predicted taken, fell through
  if (op == exu_pkg::exc_jalr) return (rs1 + imm) & 32'hffff_fffe;
  return pc + imm;
endfunction

// control transfer kind seen by the predictor
function automatic exu_pkg::jump_type_e jump_kind(exu_pkg::exc_op_e op);
  case (op)
    exu_pkg::exc_jal:    return exu_pkg::jump_jal;
    exu_pkg::exc_jalr:   return exu_pkg::jump_jalr;
    exu_pkg::exc_branch: return exu_pkg::jump_branch;
    default:             return exu_pkg::jump_none;
  endcase
endfunction

`endif

/* bench/exu_tb.sv */
`timescale 1ns/10ps

module exu_tb;

  logic             clk = 1'b0;
  logic             reset_i = 1'b1;
  logic             issue_valid_i = 1'b0;
  logic             mem_stall_i = 1'b0;
  logic [31:0]      inst_addr_i = '0;
  logic [4:0]       rd_idx_i = '0;
  logic [31:0]      rs1_data_i = '0;
  logic [31:0]      rs2_data_i = '0;
  logic [31:0]      imm_data_i = '0;
  exu_pkg::exc_op_e exc_op_i = exu_pkg::exc_none;
  exu_pkg::alu_op_e alu_op_i = exu_pkg::alu_add;
  logic [11:0]      csr_addr_i = '0;
  logic [31:0]      csr_data_i = '0;
  logic [4:0]       csr_imm_i = '0;
  logic             csr_imm_valid_i = 1'b0;
  exu_pkg::csr_op_e csr_op_i = exu_pkg::csr_none;
  logic             pdt_res_i = 1'b0;
  logic [31:0]      pdt_tag_i = '0;
  logic             which_pdt_i = 1'b0;
  logic [7:0]       history_i = '0;
  logic             mem_valid_o;
  logic [31:0]      mem_alu_data_o;
  logic [4:0]       mem_rd_idx_o;
  exu_pkg::exc_op_e mem_exc_op_o;
  logic             mem_csr_valid_o;
  logic [11:0]      mem_csr_addr_o;
  logic [31:0]      mem_csr_data_o;
  logic [31:0]      mem_rs2_data_o;
  logic [31:0]      redirect_pc_o;
  logic             redirect_pc_valid_o;
  logic             bpu_valid_o;
  logic             branch_taken_o;
  logic             pdt_correct_o;
  logic             which_pdt_o;
  logic [7:0]       history_o;
  exu_pkg::jump_type_e jump_type_o;
  logic [15:0]      branch_cnt_o;
  logic [15:0]      correct_cnt_o;

  int unsigned      err_cnt = 0;
  int unsigned      check_cnt = 0;
  int unsigned      test_cnt = 0;
  int unsigned      branch_seen = 0;   // fired branch-type instructions
  int unsigned      correct_seen = 0;
  int unsigned      stall_pct = 20;    // also the idle chance
  logic             exp_valid;
  logic             exp_csr_valid;
  logic [31:0]      exp_alu;
  logic [31:0]      exp_csr_data;
  logic [11:0]      exp_csr_addr;
  logic [31:0]      exp_rs2;
  logic [4:0]       exp_rd;
  exu_pkg::exc_op_e exp_op;

  `include "exu_model.svh"

  exu_top #(.cnt_w(16)) exu_top_i (
    .clk (clk), .reset_i (reset_i), .issue_valid_i (issue_valid_i), .mem_stall_i (mem_stall_i),
    .inst_addr_i (inst_addr_i), .rd_idx_i (rd_idx_i), .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i), .imm_data_i (imm_data_i), .exc_op_i (exc_op_i),
    .alu_op_i (alu_op_i), .csr_addr_i (csr_addr_i), .csr_data_i (csr_data_i),
    .csr_imm_i (csr_imm_i), .csr_imm_valid_i (csr_imm_valid_i), .csr_op_i (csr_op_i),
    .pdt_res_i (pdt_res_i), .pdt_tag_i (pdt_tag_i), .which_pdt_i (which_pdt_i),
    .history_i (history_i), .mem_valid_o (mem_valid_o), .mem_alu_data_o (mem_alu_data_o),
    .mem_rd_idx_o (mem_rd_idx_o), .mem_exc_op_o (mem_exc_op_o),
    .mem_csr_valid_o (mem_csr_valid_o), .mem_csr_addr_o (mem_csr_addr_o),
    .mem_csr_data_o (mem_csr_data_o), .mem_rs2_data_o (mem_rs2_data_o),
    .redirect_pc_o (redirect_pc_o),
    .redirect_pc_valid_o (redirect_pc_valid_o), .bpu_valid_o (bpu_valid_o),
    .branch_taken_o (branch_taken_o), .pdt_correct_o (pdt_correct_o),
    .which_pdt_o (which_pdt_o), .history_o (history_o), .jump_type_o (jump_type_o),
    .branch_cnt_o (branch_cnt_o), .correct_cnt_o (correct_cnt_o)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // new issue slot, a stalled instruction stays as it is
  task automatic drive_next(input int kind);
    int unsigned      k;
    exu_pkg::exc_op_e op;
    exu_pkg::alu_op_e aop;
    logic [31:0]      pc;
    logic [31:0]      rs1;
    mem_stall_i <= ($urandom % 100) < stall_pct;
    if (issue_valid_i && mem_stall_i)  // values before this edge
      return;
    k = (kind == 3) ? $urandom % 3 : kind;
    pc = $urandom & 32'hffff_fffc;
    rs1 = $urandom;
    aop = exu_pkg::alu_add;
    case (k)
      0: case ($urandom % 6)
        0: op = exu_pkg::exc_opreg;
        1: op = exu_pkg::exc_opimm;
        2: op = exu_pkg::exc_lui;
        3: op = exu_pkg::exc_auipc;
        4: op = exu_pkg::exc_jal;
        default: op = exu_pkg::exc_load;
      endcase
      1: begin
        op = exu_pkg::exc_csr;
        if ($urandom % 4 == 0) rs1 = '0;  // zero source
      end
      default: case ($urandom % 4)
        0: op = exu_pkg::exc_jal;
        1: op = exu_pkg::exc_jalr;
        default: op = exu_pkg::exc_branch;
      endcase
    endcase
    if (op == exu_pkg::exc_opreg || op == exu_pkg::exc_opimm)
      aop = exu_pkg::alu_op_e'($urandom % 10);
    if (op == exu_pkg::exc_branch)
      aop = exu_pkg::alu_op_e'(10 + $urandom % 6);
    issue_valid_i   <= ($urandom % 100) >= stall_pct;
    inst_addr_i     <= pc;
    rd_idx_i        <= 5'($urandom);
    rs1_data_i      <= rs1;
    rs2_data_i      <= ($urandom % 3 == 0) ? rs1 : $urandom;  // equal operands now and then
    imm_data_i      <= $urandom;
    exc_op_i        <= op;
    alu_op_i        <= aop;
    csr_addr_i      <= 12'($urandom);
    csr_data_i      <= $urandom;
    csr_imm_i       <= ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
    csr_imm_valid_i <= 1'($urandom);
    csr_op_i        <= (k == 1) ? exu_pkg::csr_op_e'(1 + $urandom % 3) : exu_pkg::csr_none;
    pdt_res_i       <= 1'($urandom);
    pdt_tag_i       <= ($urandom % 4 == 0) ? $urandom : pc;
    which_pdt_i     <= 1'($urandom);
    history_i       <= 8'($urandom);
  endtask

  task automatic run_test(input string name, input int kind, input int unsigned wanted);
    int unsigned fires;
    int unsigned cycles;
    int unsigned err0;
    fires = 0;
    cycles = 0;
    err0 = err_cnt;
    while (fires < wanted) begin
      if (cycles == wanted * 20) begin
        $display("timed out waiting for %0d fired instructions in %s", wanted, name);
        $display("*** TEST FAILED ***");
        $finish;
      end
      @(posedge clk);
      if (issue_valid_i && !mem_stall_i)
        fires++;
      drive_next(kind);
      cycles++;
    end
    @(posedge clk);
    if (issue_valid_i && mem_stall_i) begin  // let the held one go
      mem_stall_i <= 1'b0;
      @(posedge clk);
    end
    issue_valid_i <= 1'b0;
    mem_stall_i   <= 1'b0;
    repeat (2) @(posedge clk);
    test_cnt++;
    $display("test %s: %0d instructions, %0d errors", name, fires, err_cnt - err0);
  endtask

  // stage outputs against the expected register, then predict the next edge
  always @(negedge clk) begin
    logic taken;
    logic ok;
    logic jump;
    logic [31:0] src;
    if (reset_i) begin
      exp_valid     = 1'b0;
      exp_csr_valid = 1'b0;
    end else begin
      check_word("mem_valid_o", mem_valid_o, exp_valid);
      check_word("mem_csr_valid_o", mem_csr_valid_o, exp_csr_valid);
      if (exp_valid) begin
        check_word("mem_alu_data_o", mem_alu_data_o, exp_alu);
        check_word("mem_rd_idx_o", mem_rd_idx_o, exp_rd);
        check_word("mem_exc_op_o", mem_exc_op_o, exp_op);
        check_word("mem_csr_addr_o", mem_csr_addr_o, exp_csr_addr);
        check_word("mem_rs2_data_o", mem_rs2_data_o, exp_rs2);
        if (exp_op == exu_pkg::exc_csr)
          check_word("mem_csr_data_o", mem_csr_data_o, exp_csr_data);
      end
      taken = resolve_taken(exc_op_i, alu_op_i, rs1_data_i, rs2_data_i);
      ok    = prediction_ok(taken, pdt_res_i, pdt_tag_i, inst_addr_i);
      jump  = exc_op_i == exu_pkg::exc_branch || exc_op_i == exu_pkg::exc_jal ||
              exc_op_i == exu_pkg::exc_jalr;
      check_word("jump_type_o", jump_type_o, jump_kind(exc_op_i));
      if (issue_valid_i && jump) begin
        check_word("bpu_valid_o", bpu_valid_o, 1'b1);
        check_word("branch_taken_o", branch_taken_o, taken);
        check_word("pdt_correct_o", pdt_correct_o, ok);
        check_word("redirect_pc_valid_o", redirect_pc_valid_o, !ok);
        check_word("which_pdt_o", which_pdt_o, which_pdt_i);
        check_word("history_o", history_o, history_i);
        if (!ok)
          check_word("redirect_pc_o", redirect_pc_o, redirect_target(exc_op_i, taken,
                     pdt_res_i, inst_addr_i, rs1_data_i, imm_data_i));
      end else begin
        check_word("bpu_valid_o", bpu_valid_o, 1'b0);
        check_word("redirect_pc_valid_o", redirect_pc_valid_o, 1'b0);
      end
      if (issue_valid_i && !mem_stall_i) begin
        src           = csr_source(rs1_data_i, csr_imm_i, csr_imm_valid_i);
        exp_valid     = 1'b1;
        exp_alu       = execute_result(exc_op_i, alu_op_i, inst_addr_i, rs1_data_i,
                                       rs2_data_i, imm_data_i, csr_data_i);
        exp_rd        = rd_idx_i;
        exp_op        = exc_op_i;
        exp_csr_addr  = csr_addr_i;
        exp_rs2       = rs2_data_i;
        exp_csr_data  = csr_new_value(csr_data_i, src, csr_op_i);
        exp_csr_valid = exc_op_i == exu_pkg::exc_csr && csr_writes(src, csr_op_i);
        branch_seen   += jump;
        correct_seen  += jump && ok;
      end else if (!mem_stall_i) begin
        exp_valid     = 1'b0;  // bubble
        exp_csr_valid = 1'b0;
      end
    end
  end

  initial begin
    int unsigned err0;
    void'($urandom(51696));
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;
    for (int i = 0; reset_i !== 1'b0; i++) begin
      if (i == 10) begin
        $display("timed out waiting for reset release");
        $display("*** TEST FAILED ***");
        $finish;
      end
      @(negedge clk);
    end
    check_word("branch_cnt_o after reset", branch_cnt_o, 32'd0);
    check_word("correct_cnt_o after reset", correct_cnt_o, 32'd0);
    test_cnt++;
    $display("test reset: %0d errors", err_cnt);
    run_test("alu and operands", 0, 300);
    run_test("csr execute", 1, 200);
    run_test("branch resolution", 2, 300);
    stall_pct = 50;
    run_test("stall and bubbles", 3, 300);
    stall_pct = 20;
    run_test("branch run for statistics", 2, 200);
    @(negedge clk);
    err0 = err_cnt;
    check_word("branch_cnt_o", branch_cnt_o, branch_seen);
    check_word("correct_cnt_o", correct_cnt_o, correct_seen);
    test_cnt++;
    $display("test statistics: %0d branches, %0d errors", branch_seen, err_cnt - err0);
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+bench
design/exu_pkg.sv
design/alu.sv
design/execute_csr.sv
design/exu.sv
design/ex_mem_reg.sv
design/bpu_stat.sv
design/exu_top.sv
bench/exu_tb.sv
